//--- tb.f
verilog/execPkg.sv
verilog/binaryAlu.sv
verilog/decimalAlu.sv
verilog/accumStatus.sv
verilog/execHandshake.sv
verilog/execUnit.sv
verification/execUnit_assert.sv
verification/execUnitTb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= execUnitTb
FILELIST ?= tb.f
BUILD    ?= obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- verification/execUnitTb.sv
/* execUnitTb: drives the execution unit through req/ack operations,
   results and timing are checked by the bound assertions */

`default_nettype none

module execUnitTb import execPkg::*; ();

    localparam int dataWidth  = 8;
    localparam int maxOps     = 40;
    localparam int cycleLimit = maxOps * 8 + 50;

    logic                 rstAll;
    logic                 rstN;
    logic                 req;
    opCode                op;
    logic [dataWidth-1:0] operand;
    logic                 ack;
    logic [dataWidth-1:0] acc;
    statusFlags           status;
    logic [31:0]          lcgState;
    int                   cycles;

    execUnit #(.dataWidth(dataWidth)) dut_i (
        .rstAll  (rstAll),
        .rstN    (rstN),
        .req     (req),
        .op      (op),
        .operand (operand),
        .ack     (ack),
        .acc     (acc),
        .status  (status)
    );

    initial begin
        rstAll = 1'b0;
        forever #5 rstAll = ~rstAll;
    end

    function automatic logic [7:0] randomByte();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:24];
    endfunction

    // two decimal digits taken from one random byte
    function automatic logic [7:0] randomBcd();
        logic [7:0] r;
        r = randomByte();
        return {r[7:4] % 4'd10, r[3:0] % 4'd10};
    endfunction

    // one four-phase transfer, req held for extra cycles after ack if asked
    task automatic runOp(input opCode o, input logic [dataWidth-1:0] value,
            input int holdCycles);
        req     <= 1'b1;
        op      <= o;
        operand <= value;
        @(posedge rstAll);
        while (!ack) @(posedge rstAll);
        repeat (holdCycles) @(posedge rstAll);
        req <= 1'b0;
        @(posedge rstAll);
        while (ack) @(posedge rstAll);
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge rstAll);
            cycles++;
            if (dut_i.chk.errorCount != 0) begin
                $display("test failed");
                $fatal(1, "bound assertion reported a mismatch");
            end else if (cycles > cycleLimit) begin
                $display("timeout: ack never completed");
                $display("test failed");
                $fatal(1, "cycle limit reached");
            end
        end
    end

    initial begin
        req      = 1'b0;
        op       = opLda;
        operand  = '0;
        rstN     = 1'b0;
        lcgState = 32'h9e32_a38c;
        repeat (2) @(posedge rstAll);
        rstN <= 1'b1;
        @(posedge rstAll);

        // binary mode and overflow corners
        runOp(opCld, randomByte(), 0);
        runOp(opClc, randomByte(), 0);
        runOp(opLda, 8'h7f, 0);
        runOp(opAdc, 8'h01, 0);
        runOp(opLda, 8'h80, 0);
        runOp(opSec, randomByte(), 0);
        runOp(opSbc, 8'h01, 0);
        for (int i = 0; i < 6; i++) begin
            runOp((i % 2 == 0) ? opAdc : opSbc, randomByte(), 0);
        end

        // logic, load and shift
        runOp(opLda, randomByte(), 0);
        runOp(opAnd, randomByte(), 0);
        runOp(opOra, randomByte(), 0);
        runOp(opEor, randomByte(), 0);
        runOp(opLsr, randomByte(), 0);
        runOp(opLsr, randomByte(), 0);
        runOp(opLda, 8'h00, 0);
        runOp(opLda, 8'h01, 0);
        runOp(opLsr, randomByte(), 0);

        // flag operations, first one with req held past ack
        runOp(opSec, randomByte(), 3);
        runOp(opSed, randomByte(), 0);
        runOp(opCld, randomByte(), 0);
        runOp(opClc, randomByte(), 0);

        // decimal mode
        runOp(opSed, randomByte(), 0);
        runOp(opLda, 8'h99, 0);
        runOp(opClc, randomByte(), 0);
        runOp(opAdc, 8'h01, 0);
        runOp(opLda, 8'h00, 0);
        runOp(opSec, randomByte(), 0);
        runOp(opSbc, 8'h01, 0);
        for (int i = 0; i < 4; i++) begin
            runOp((i % 2 == 0) ? opAdc : opSbc, randomBcd(), 0);
        end
        runOp(opCld, randomByte(), 0);

        repeat (2) @(posedge rstAll);
        if (dut_i.chk.errorCount == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- verification/execUnit_assert.sv
/* execUnitAssert checks the handshake timing and compares the accumulator
   and flags with a reference model after each operation */

`default_nettype none

module execUnitAssert import execPkg::*; #(
    parameter int dataWidth = 8
) (
    input logic                 rstAll,
    input logic                 rstN,
    input logic                 req,
    input opCode                op,
    input logic [dataWidth-1:0] operand,
    input logic                 ack,
    input logic [dataWidth-1:0] acc,
    input statusFlags           status
);

    localparam int msb = dataWidth - 1;

    logic                 reqPrev;
    logic                 acceptReq;
    logic                 fellReq;
    logic [dataWidth-1:0] expAcc;
    statusFlags           expStatus;
    int                   errorCount = 0;

    function automatic int bcdToInt(input logic [dataWidth-1:0] value);
        int r;
        r = 0;
        for (int i = dataWidth / 4 - 1; i >= 0; i--) begin
            r = r * 10 + int'(value[4*i +: 4]);
        end
        return r;
    endfunction

    function automatic logic [dataWidth-1:0] intToBcd(input int value);
        logic [dataWidth-1:0] r;
        int                   rest;
        r    = '0;
        rest = value;
        for (int i = 0; i < dataWidth / 4; i++) begin
            r[4*i +: 4] = 4'(rest % 10);
            rest        = rest / 10;
        end
        return r;
    endfunction

    // expected {status, acc} after one operation
    function automatic logic [dataWidth+4:0] predict(input opCode o,
            input logic [dataWidth-1:0] b, input logic [dataWidth-1:0] a,
            input statusFlags s);
        logic [dataWidth-1:0] res;
        logic [dataWidth-1:0] addend;
        logic [dataWidth:0]   sum;
        int                   sgnSum;
        int                   decVal;
        int                   decMod;
        statusFlags           f;
        f      = s;
        res    = a;
        addend = (o == opSbc) ? ~b : b;
        sum    = {1'b0, a} + {1'b0, addend} + {{dataWidth{1'b0}}, s.c};
        sgnSum = int'($signed(a)) + int'($signed(addend)) + int'(s.c);
        decMod = 10 ** (dataWidth / 4);
        decVal = 0;
        case (o)
            opLda: res = b;
            opAnd: res = a & b;
            opOra: res = a | b;
            opEor: res = a ^ b;
            opLsr: begin
                res = a >> 1;
                f.c = a[0];
            end
            opAdc, opSbc: begin
                res = sum[msb:0];
                f.c = sum[dataWidth];
                // signed sum outside the two's complement range
                f.v = (sgnSum > (2 ** msb - 1)) || (sgnSum < -(2 ** msb));
                // decimal value arithmetic on whole BCD numbers
                if (s.d) begin
                    if (o == opAdc) begin
                        decVal = bcdToInt(a) + bcdToInt(b) + int'(s.c);
                        f.c    = (decVal >= decMod);
                    end else begin
                        decVal = bcdToInt(a) - bcdToInt(b) - (1 - int'(s.c));
                        f.c    = (decVal >= 0);
                    end
                    res = intToBcd((decVal + decMod) % decMod);
                end
            end
            opSec: f.c = 1'b1;
            opClc: f.c = 1'b0;
            opSed: f.d = 1'b1;
            opCld: f.d = 1'b0;
            default: f = s;
        endcase
        if (!(o inside {opSec, opClc, opSed, opCld})) begin
            f.n = res[msb];
            f.z = (res == '0);
        end
        return {f, res};
    endfunction

    assign acceptReq = req && !reqPrev;
    assign fellReq   = !req && reqPrev;

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            reqPrev <= 1'b0;
        end else begin
            reqPrev <= req;
            if (acceptReq) begin
                {expStatus, expAcc} <= predict(op, operand, acc, status);
            end
        end
    end

    ackAfterReset: assert property (@(posedge rstAll) !rstN |=> !ack)
        else begin
            errorCount++;
            $error("ack was high right after reset");
        end

    ackRise: assert property (@(posedge rstAll) disable iff (!rstN)
        $past(acceptReq, 3) == $rose(ack))
        else begin
            errorCount++;
            $error("ack did not rise two cycles after the request was accepted");
        end

    ackHold: assert property (@(posedge rstAll) disable iff (!rstN)
        (ack && req) |=> ack)
        else begin
            errorCount++;
            $error("ack dropped while req was still high");
        end

    ackFall: assert property (@(posedge rstAll) disable iff (!rstN)
        $past(fellReq, 2) == $fell(ack))
        else begin
            errorCount++;
            $error("ack did not fall one cycle after req was sampled low");
        end

    accResult: assert property (@(posedge rstAll) disable iff (!rstN)
        $rose(ack) |-> (acc == expAcc))
        else begin
            errorCount++;
            $error("Error acc exp %h got %h", expAcc, acc);
        end

    statusResult: assert property (@(posedge rstAll) disable iff (!rstN)
        $rose(ack) |-> (status == expStatus))
        else begin
            errorCount++;
            $error("Error status exp %h got %h", expStatus, status);
        end

endmodule

bind execUnit execUnitAssert #(.dataWidth(dataWidth)) chk (
    .rstAll  (rstAll),
    .rstN    (rstN),
    .req     (req),
    .op      (op),
    .operand (operand),
    .ack     (ack),
    .acc     (acc),
    .status  (status)
);

`default_nettype wire

//--- verilog/execUnit.sv
/* execUnit: accumulator execution unit top, handshake controller feeding
   the binary and decimal ALUs and the accumulator/status register */

`default_nettype none

module execUnit import execPkg::*; #(
    parameter int dataWidth = 8
) (
    input  logic                 rstAll,
    input  logic                 rstN,
    input  logic                 req,
    input  opCode                op,
    input  logic [dataWidth-1:0] operand,
    output logic                 ack,
    output logic [dataWidth-1:0] acc,
    output statusFlags           status
);

    opCode                curOp;
    logic [dataWidth-1:0] curOperand;
    logic                 commit;
    logic [dataWidth-1:0] binResult;
    aluFlags              binFlags;
    logic [dataWidth-1:0] decResult;
    aluFlags              decFlags;

    execHandshake #(.dataWidth(dataWidth)) handshake (
        .rstAll     (rstAll),
        .rstN       (rstN),
        .req        (req),
        .op         (op),
        .operand    (operand),
        .ack        (ack),
        .curOp      (curOp),
        .curOperand (curOperand),
        .commit     (commit)
    );

    // both ALUs see the same operands, status.c is the carry in
    binaryAlu #(.dataWidth(dataWidth)) binAlu (
        .curOp      (curOp),
        .curOperand (curOperand),
        .acc        (acc),
        .carryIn    (status.c),
        .binResult  (binResult),
        .binFlags   (binFlags)
    );

    decimalAlu #(.dataWidth(dataWidth)) decAlu (
        .curOp      (curOp),
        .curOperand (curOperand),
        .acc        (acc),
        .carryIn    (status.c),
        .decResult  (decResult),
        .decFlags   (decFlags)
    );

    accumStatus #(.dataWidth(dataWidth)) accStat (
        .rstAll     (rstAll),
        .rstN       (rstN),
        .commit     (commit),
        .curOp      (curOp),
        .binResult  (binResult),
        .binFlags   (binFlags),
        .decResult  (decResult),
        .decFlags   (decFlags),
        .acc        (acc),
        .status     (status)
    );

endmodule

`default_nettype wire

//--- verilog/execHandshake.sv
/* execHandshake: four-phase req/ack controller, latches the operation on
   acceptance and issues one commit pulse per request */

`default_nettype none

module execHandshake import execPkg::*; #(
    parameter int dataWidth = 8
) (
    input  logic                 rstAll,
    input  logic                 rstN,
    input  logic                 req,
    input  opCode                op,
    input  logic [dataWidth-1:0] operand,
    output logic                 ack,
    output opCode                curOp,
    output logic [dataWidth-1:0] curOperand,
    output logic                 commit
);

    hsState state;
    logic   accept;

    // a new request is taken only from idle, so ack has already fallen
    assign accept = (state == hsIdle) && req;

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            state  <= hsIdle;
            ack    <= 1'b0;
            commit <= 1'b0;
        end else begin
            commit <= 1'b0;
            case (state)
                hsIdle: begin
                    if (req) begin
                        state <= hsExec;
                    end
                end
                hsExec: begin
                    commit <= 1'b1;
                    state  <= hsAck;
                end
                hsAck: begin
                    // ack rises with the accumulator update
                    ack <= 1'b1;
                    if (ack && !req) begin
                        state <= hsWait;
                    end
                end
                hsWait: begin
                    ack   <= 1'b0;
                    state <= hsIdle;
                end
                default: begin
                    state <= hsIdle;
                end
            endcase
        end
    end

    // operation held stable for the ALUs until the next acceptance
    always_ff @(posedge rstAll) begin
        if (accept) begin
            curOp      <= op;
            curOperand <= operand;
        end
    end

endmodule

`default_nettype wire

//--- verilog/accumStatus.sv
/* accumStatus: selects binary or decimal result by the D flag and holds
   the accumulator and the N V D Z C status flags */

`default_nettype none

module accumStatus import execPkg::*; #(
    parameter int dataWidth = 8
) (
    input  logic                 rstAll,
    input  logic                 rstN,
    input  logic                 commit,
    input  opCode                curOp,
    input  logic [dataWidth-1:0] binResult,
    input  aluFlags              binFlags,
    input  logic [dataWidth-1:0] decResult,
    input  aluFlags              decFlags,
    output logic [dataWidth-1:0] acc,
    output statusFlags           status
);

    logic                 isArith;
    logic                 useDecimal;
    logic [dataWidth-1:0] newAcc;
    logic                 newCarry;
    logic                 newNeg;
    logic                 newZero;

    assign isArith = (curOp == opAdc) || (curOp == opSbc);

    // decimal result only for add and subtract with D set
    assign useDecimal = status.d && isArith;
    assign newAcc     = useDecimal ? decResult : binResult;
    assign newCarry   = useDecimal ? decFlags.carry : binFlags.carry;

    assign newNeg  = newAcc[dataWidth-1];
    assign newZero = (newAcc == '0);

    always_ff @(posedge rstAll) begin
        if (!rstN) begin
            acc    <= '0;
            status <= '0;
        end else if (commit) begin
            case (curOp)
                opLda, opAnd, opOra, opEor: begin
                    acc      <= newAcc;
                    status.n <= newNeg;
                    status.z <= newZero;
                end
                opAdc, opSbc: begin
                    acc      <= newAcc;
                    status.n <= newNeg;
                    // V comes from the binary adder even in decimal mode
                    status.v <= binFlags.overflow;
                    status.z <= newZero;
                    status.c <= newCarry;
                end
                opLsr: begin
                    // top bit is shifted in as zero, so N clears
                    acc      <= newAcc;
                    status.n <= newNeg;
                    status.z <= newZero;
                    status.c <= newCarry;
                end
                opSec: begin
                    status.c <= 1'b1;
                end
                opClc: begin
                    status.c <= 1'b0;
                end
                opSed: begin
                    status.d <= 1'b1;
                end
                opCld: begin
                    status.d <= 1'b0;
                end
                default: begin
                    acc <= acc;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/decimalAlu.sv
/* decimalAlu: combinational BCD add and subtract, one nibble at a time
   with carry or borrow rippling upward */

`default_nettype none

module decimalAlu import execPkg::*; #(
    parameter int dataWidth = 8
) (
    input  opCode                curOp,
    input  logic [dataWidth-1:0] curOperand,
    input  logic [dataWidth-1:0] acc,
    input  logic                 carryIn,
    output logic [dataWidth-1:0] decResult,
    output aluFlags              decFlags
);

    localparam int numNibbles = dataWidth / 4;

    logic                 isAdd;
    logic                 isSub;
    logic [dataWidth-1:0] bcdValue;
    logic [4:0]           nib;
    logic                 chain;
    logic                 lowChain;

    assign isAdd = (curOp == opAdc);
    assign isSub = (curOp == opSbc);

    // chain is a carry on add and a borrow on subtract
    always_comb begin
        chain    = isSub ? ~carryIn : carryIn;
        lowChain = chain;
        bcdValue = '0;
        nib      = '0;
        for (int i = 0; i < numNibbles; i++) begin
            if (isSub) begin
                nib   = {1'b0, acc[4*i +: 4]} - {1'b0, curOperand[4*i +: 4]} - {4'd0, chain};
                chain = nib[4];
                // borrowed nibble wraps past 9, pull it back into range
                if (chain) begin
                    nib = nib - 5'd6;
                end
            end else begin
                nib   = {1'b0, acc[4*i +: 4]} + {1'b0, curOperand[4*i +: 4]} + {4'd0, chain};
                chain = (nib > 5'd9);
                // skip the six unused codes A..F
                if (chain) begin
                    nib = nib + 5'd6;
                end
            end
            bcdValue[4*i +: 4] = nib[3:0];
            if (i == 0) begin
                lowChain = chain;
            end
        end
    end

    assign decResult = (isAdd || isSub) ? bcdValue : acc;

    // carry out is the inverse of the final borrow on subtract
    assign decFlags.carry     = isSub ? ~chain : chain;
    assign decFlags.halfCarry = isSub ? ~lowChain : lowChain;
    // V is taken from the binary ALU in decimal mode
    assign decFlags.overflow  = 1'b0;

endmodule

`default_nettype wire

//--- verilog/binaryAlu.sv
/* binaryAlu: combinational binary add, subtract, logic, shift and load
   on the accumulator and the latched operand */

`default_nettype none

module binaryAlu import execPkg::*; #(
    parameter int dataWidth = 8
) (
    input  opCode                curOp,
    input  logic [dataWidth-1:0] curOperand,
    input  logic [dataWidth-1:0] acc,
    input  logic                 carryIn,
    output logic [dataWidth-1:0] binResult,
    output aluFlags              binFlags
);

    logic [dataWidth-1:0] addend;
    logic [dataWidth:0]   sum;
    logic [4:0]           lowSum;

    // subtract is an add of the inverted operand
    assign addend = (curOp == opSbc) ? ~curOperand : curOperand;

    // full sum gives carry out, low nibble alone gives half carry
    assign sum    = {1'b0, acc} + {1'b0, addend} + {{dataWidth{1'b0}}, carryIn};
    assign lowSum = {1'b0, acc[3:0]} + {1'b0, addend[3:0]} + {4'd0, carryIn};

    always_comb begin
        binResult = acc;
        binFlags  = '0;
        case (curOp)
            opAdc, opSbc: begin
                binResult          = sum[dataWidth-1:0];
                binFlags.carry     = sum[dataWidth];
                binFlags.halfCarry = lowSum[4];
                // signed overflow when both addends agree in sign and the sum does not
                binFlags.overflow  = (acc[dataWidth-1] == addend[dataWidth-1]) &&
                                     (sum[dataWidth-1] != acc[dataWidth-1]);
            end
            opAnd: begin
                binResult = acc & curOperand;
            end
            opOra: begin
                binResult = acc | curOperand;
            end
            opEor: begin
                binResult = acc ^ curOperand;
            end
            opLsr: begin
                // zero shifted into the top, bit 0 goes to carry
                binResult      = {1'b0, acc[dataWidth-1:1]};
                binFlags.carry = acc[0];
            end
            opLda: begin
                binResult = curOperand;
            end
            default: begin
                // flag operations leave the accumulator value as is
                binResult = acc;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/execPkg.sv
/* execPkg: shared opcode, handshake state and flag types for the
   accumulator execution unit */

`default_nettype none

package execPkg;

    // operations accepted by the execution unit
    typedef enum logic [3:0] {
        opLda,
        opAdc,
        opSbc,
        opAnd,
        opOra,
        opEor,
        opLsr,
        opSec,
        opClc,
        opSed,
        opCld
    } opCode;

    // four-phase req/ack controller states
    typedef enum logic [1:0] {
        hsIdle,
        hsExec,
        hsAck,
        hsWait
    } hsState;

    // architectural status flags, ordered as in the 6502 P register
    typedef struct packed {
        logic n;
        logic v;
        logic d;
        logic z;
        logic c;
    } statusFlags;

    // flags produced by both ALUs
    typedef struct packed {
        logic carry;
        logic overflow;
        logic halfCarry;
    } aluFlags;

endpackage

`default_nettype wire
